// File: rtl/soc_pkg.sv
package soc_pkg;

	// ========================================
	// Bus transfer types
	// ========================================

	// Held by the requester until ready
	typedef struct packed {
		logic        request;
		logic        rw;       // 1 = write
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Ready is a single-cycle pulse
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	// ========================================
	// Memory map
	// ========================================

	// Ranges are half open, base included and limit excluded
	localparam logic [31:0] ROM_BASE    = 32'h0000_0000;
	localparam logic [31:0] ROM_LIMIT   = 32'h0001_0000;

	localparam logic [31:0] RAM_BASE    = 32'h0001_0000;
	localparam logic [31:0] RAM_LIMIT   = 32'h0002_0000;

	localparam logic [31:0] LED_BASE    = 32'h5000_0000;
	localparam logic [31:0] LED_LIMIT   = 32'h5000_0010;

	localparam logic [31:0] TIMER_BASE  = 32'h6000_0000;
	localparam logic [31:0] TIMER_LIMIT = 32'h6000_0020;

	// ========================================
	// Sizes
	// ========================================

	localparam int ROM_WORDS = 16;
	localparam int RAM_WORDS = 1024;
	localparam int LED_WIDTH = 10;

	// Timer register index, address bits 4:2
	localparam logic [2:0] TMR_CYCLES   = 3'd0;
	localparam logic [2:0] TMR_PA_COUNT = 3'd1;
	localparam logic [2:0] TMR_PB_COUNT = 3'd2;

endpackage

// File: rtl/bus_access.sv
module bus_access (
	input  logic              clock,
	input  logic              i_rst_n,

	// Port A, instruction fetch, read only
	input  logic              i_pa_request,
	input  logic [31:0]       i_pa_address,
	output soc_pkg::bus_rsp_t o_pa,

	// Port B, data access
	input  soc_pkg::bus_req_t i_pb,
	output soc_pkg::bus_rsp_t o_pb,

	// Shared bus towards the decoder
	output soc_pkg::bus_req_t o_bus_req,
	input  soc_pkg::bus_rsp_t i_bus_rsp,

	// Finished transactions per port
	output logic [31:0]       o_pa_count,
	output logic [31:0]       o_pb_count
);

	logic busy;
	logic owner_b;
	logic done;
	logic pa_pending;
	logic pb_pending;
	logic grant_b;
	logic finish;

	// Port just served may still hold its request for one cycle
	assign pa_pending = i_pa_request && !(done && !owner_b);
	assign pb_pending = i_pb.request && !(done && owner_b);

	// On a tie the port not served last wins
	assign grant_b = pb_pending && (!pa_pending || !owner_b);

	assign finish = busy && i_bus_rsp.ready;

	// ========================================
	// Arbiter FSM, idle and busy
	// ========================================

	// owner_b keeps the last granted port while idle, reset favours B
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			busy    <= 1'b0;
			owner_b <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			done <= finish;
			if (!busy)
			begin
				if (pa_pending || pb_pending)
				begin
					busy    <= 1'b1;
					owner_b <= grant_b;
				end
			end
			else if (i_bus_rsp.ready)
				busy <= 1'b0;
		end
	end

	// Bus driven from the granted port only while busy
	always_comb
	begin
		o_bus_req.request = busy;
		o_bus_req.rw      = owner_b && i_pb.rw;
		o_bus_req.address = owner_b ? i_pb.address : i_pa_address;
		o_bus_req.wdata   = owner_b ? i_pb.wdata : 32'h0;
	end

	// Ready goes back to the owner only
	assign o_pa.ready = finish && !owner_b;
	assign o_pa.rdata = i_bus_rsp.rdata;
	assign o_pb.ready = finish && owner_b;
	assign o_pb.rdata = i_bus_rsp.rdata;

	// Debug counters
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_pa_count <= 32'h0;
			o_pb_count <= 32'h0;
		end
		else
		begin
			if (o_pa.ready)
				o_pa_count <= o_pa_count + 32'd1;
			if (o_pb.ready)
				o_pb_count <= o_pb_count + 32'd1;
		end
	end

endmodule

// File: rtl/bus_decoder.sv
module bus_decoder (
	input  logic              clock,
	input  logic              i_rst_n,

	input  soc_pkg::bus_req_t i_bus_req,
	output soc_pkg::bus_rsp_t o_bus_rsp,

	output soc_pkg::bus_req_t o_rom_req,
	input  soc_pkg::bus_rsp_t i_rom_rsp,
	output soc_pkg::bus_req_t o_ram_req,
	input  soc_pkg::bus_rsp_t i_ram_rsp,
	output soc_pkg::bus_req_t o_led_req,
	input  soc_pkg::bus_rsp_t i_led_rsp,
	output soc_pkg::bus_req_t o_tmr_req,
	input  soc_pkg::bus_rsp_t i_tmr_rsp
);

	import soc_pkg::*;

	logic rom_sel;
	logic ram_sel;
	logic led_sel;
	logic tmr_sel;
	logic none_sel;
	logic unm_ready;

	// Target view of the bus, offset from its base
	function automatic bus_req_t route(input bus_req_t req, input logic sel,
		input logic [31:0] base);
		bus_req_t r;
		r         = req;
		r.request = req.request && sel;
		r.address = req.address - base;
		return r;
	endfunction

	assign rom_sel  = (i_bus_req.address >= ROM_BASE) && (i_bus_req.address < ROM_LIMIT);
	assign ram_sel  = (i_bus_req.address >= RAM_BASE) && (i_bus_req.address < RAM_LIMIT);
	assign led_sel  = (i_bus_req.address >= LED_BASE) && (i_bus_req.address < LED_LIMIT);
	assign tmr_sel  = (i_bus_req.address >= TIMER_BASE) && (i_bus_req.address < TIMER_LIMIT);
	assign none_sel = !(rom_sel || ram_sel || led_sel || tmr_sel);

	assign o_rom_req = route(i_bus_req, rom_sel, ROM_BASE);
	assign o_ram_req = route(i_bus_req, ram_sel, RAM_BASE);
	assign o_led_req = route(i_bus_req, led_sel, LED_BASE);
	assign o_tmr_req = route(i_bus_req, tmr_sel, TIMER_BASE);

	// Unmapped address, answer with zero instead of hanging the bus
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			unm_ready <= 1'b0;
		else
			unm_ready <= i_bus_req.request && none_sel && !unm_ready;
	end

	always_comb
	begin
		o_bus_rsp.ready = unm_ready;
		o_bus_rsp.rdata = 32'h0;
		if (rom_sel)
			o_bus_rsp = i_rom_rsp;
		else if (ram_sel)
			o_bus_rsp = i_ram_rsp;
		else if (led_sel)
			o_bus_rsp = i_led_rsp;
		else if (tmr_sel)
			o_bus_rsp = i_tmr_rsp;
	end

endmodule

// File: rtl/block_ram.sv
module block_ram #(
	parameter int DEPTH = soc_pkg::RAM_WORDS
) (
	input  logic              clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);

	logic [31:0]              mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] word_idx;
	logic [31:0]              rdata_q;
	logic                     ready_q;
	logic                     accept;

	// Word index wraps at DEPTH
	assign word_idx = i_req.address[$clog2(DEPTH)+1:2];

	// Skip the request still held in the cycle after ready
	assign accept = i_req.request && !ready_q;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= accept;
	end

	always_ff @(posedge clock)
	begin
		if (accept && i_req.rw)
			mem[word_idx] <= i_req.wdata;
		if (accept)
			rdata_q <= mem[word_idx];
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

// File: rtl/boot_rom.sv
module boot_rom (
	input  logic              clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);

	import soc_pkg::*;

	logic [31:0]                  rom [ROM_WORDS];
	logic [$clog2(ROM_WORDS)-1:0] word_idx;
	logic [31:0]                  rdata_q;
	logic                         ready_q;
	logic                         accept;

	initial
		$readmemh("boot_rom.hex", rom);

	assign word_idx = i_req.address[$clog2(ROM_WORDS)+1:2];
	assign accept   = i_req.request && !ready_q;

	// Writes still complete, contents stay as loaded
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= accept;
	end

	always_ff @(posedge clock)
		if (accept)
			rdata_q <= rom[word_idx];

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

// File: rtl/led_port.sv
module led_port (
	input  logic                          clock,
	input  logic                          i_rst_n,
	input  soc_pkg::bus_req_t             i_req,
	output soc_pkg::bus_rsp_t             o_rsp,
	output logic [soc_pkg::LED_WIDTH-1:0] o_leds
);

	import soc_pkg::*;

	logic ready_q;
	logic accept;

	assign accept = i_req.request && !ready_q;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			ready_q <= 1'b0;
			o_leds  <= '0;
		end
		else
		begin
			ready_q <= accept;
			if (accept && i_req.rw)
				o_leds <= i_req.wdata[LED_WIDTH-1:0];
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = {{(32-LED_WIDTH){1'b0}}, o_leds};

endmodule

// File: rtl/cycle_timer.sv
module cycle_timer (
	input  logic              clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,

	// Statistics from the arbiter
	input  logic [31:0]       i_pa_count,
	input  logic [31:0]       i_pb_count
);

	import soc_pkg::*;

	logic [31:0] cycles;
	logic [31:0] rdata_q;
	logic        ready_q;
	logic        accept;

	assign accept = i_req.request && !ready_q;

	// Free running from reset
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			cycles <= 32'h0;
		else
			cycles <= cycles + 32'd1;
	end

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= accept;
	end

	// Register select, writes only complete
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			case (i_req.address[4:2])
				TMR_CYCLES:   rdata_q <= cycles;
				TMR_PA_COUNT: rdata_q <= i_pa_count;
				TMR_PB_COUNT: rdata_q <= i_pb_count;
				default:      rdata_q <= 32'h0;
			endcase
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

// File: rtl/soc_top.sv
module soc_top (
	input  logic                          clock,
	input  logic                          i_rst_n,
	input  logic                          i_pa_request,
	input  logic [31:0]                   i_pa_address,
	input  soc_pkg::bus_req_t             i_pb,
	output soc_pkg::bus_rsp_t             o_pa,
	output soc_pkg::bus_rsp_t             o_pb,
	output logic [soc_pkg::LED_WIDTH-1:0] o_leds
);

	import soc_pkg::*;

	// Single shared bus
	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic [31:0] pa_count;
	logic [31:0] pb_count;

	// Target side
	bus_req_t rom_req;
	bus_rsp_t rom_rsp;
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t led_req;
	bus_rsp_t led_rsp;
	bus_req_t tmr_req;
	bus_rsp_t tmr_rsp;

	// ========================================
	// Arbiter and decoder
	// ========================================

	bus_access bus_access_i (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_pa_request (i_pa_request),
		.i_pa_address (i_pa_address),
		.o_pa         (o_pa),
		.i_pb         (i_pb),
		.o_pb         (o_pb),
		.o_bus_req    (bus_req),
		.i_bus_rsp    (bus_rsp),
		.o_pa_count   (pa_count),
		.o_pb_count   (pb_count)
	);

	bus_decoder bus_decoder_i (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_bus_req (bus_req),
		.o_bus_rsp (bus_rsp),
		.o_rom_req (rom_req),
		.i_rom_rsp (rom_rsp),
		.o_ram_req (ram_req),
		.i_ram_rsp (ram_rsp),
		.o_led_req (led_req),
		.i_led_rsp (led_rsp),
		.o_tmr_req (tmr_req),
		.i_tmr_rsp (tmr_rsp)
	);

	// ========================================
	// Targets
	// ========================================

	boot_rom boot_rom_i (.clock(clock), .i_rst_n(i_rst_n), .i_req(rom_req), .o_rsp(rom_rsp));

	block_ram #(
		.DEPTH (RAM_WORDS)
	) block_ram_i (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	led_port led_port_i (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.i_req   (led_req),
		.o_rsp   (led_rsp),
		.o_leds  (o_leds)
	);

	cycle_timer cycle_timer_i (
		.clock      (clock),
		.i_rst_n    (i_rst_n),
		.i_req      (tmr_req),
		.o_rsp      (tmr_rsp),
		.i_pa_count (pa_count),
		.i_pb_count (pb_count)
	);

endmodule

// File: sim/tb_soc.sv
module tb_soc;

	import soc_pkg::*;

	// Grant cycle in the arbiter plus the target's one cycle
	localparam int ACCESS_CYCLES = 2;
	// A served port adds its idle cycle after ready
	localparam int SLOT_CYCLES   = ACCESS_CYCLES + 1;
	localparam int RESET_CYCLES  = 10;
	localparam int READY_LIMIT   = 50;
	localparam int RAM_TRIES     = 32;
	localparam int PLANNED       = 111;

	logic                 clock = 1'b0;
	logic                 rst_n;
	logic                 pa_request;
	logic [31:0]          pa_address;
	bus_req_t             pb_req;
	bus_rsp_t             pa_rsp;
	bus_rsp_t             pb_rsp;
	logic [LED_WIDTH-1:0] leds;

	// Reference model
	logic [31:0] rom_model [ROM_WORDS];
	logic [31:0] ram_model [RAM_WORDS];
	int          ram_written [RAM_TRIES];
	logic [15:0] lfsr = 16'd48908;
	int          tb_cycles = 0;
	int          a_ready_at = 0;
	int          b_ready_at = 0;
	int          a_latency = 0;
	int          b_latency = 0;
	int          a_done = 0;
	int          b_done = 0;
	logic        last_b = 1'b0;    // A counts as served last, so B wins first

	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	// ========================================
	// Clock and DUT
	// ========================================

	always #4 clock = ~clock;

	always @(posedge clock)
		tb_cycles <= tb_cycles + 1;

	soc_top soc_top_i (
		.clock        (clock),
		.i_rst_n      (rst_n),
		.i_pa_request (pa_request),
		.i_pa_address (pa_address),
		.i_pb         (pb_req),
		.o_pa         (pa_rsp),
		.o_pb         (pb_rsp),
		.o_leds       (leds)
	);

	// ========================================
	// Helpers
	// ========================================

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = 32'h0;
		for (int i = 0; i < count; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic compare_word(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("Error at %0t: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic read_a(input logic [31:0] addr, output logic [31:0] data);
		int start;
		int waited;
		start      = tb_cycles;
		waited     = 0;
		data       = 32'h0;
		pa_request = 1'b1;
		pa_address = addr;
		@(negedge clock);
		while (!pa_rsp.ready && waited < READY_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (pa_rsp.ready)
		begin
			data       = pa_rsp.rdata;
			a_ready_at = tb_cycles;
			a_latency  = tb_cycles - start;
			a_done++;
			last_b = 1'b0;
		end
		else
		begin
			timeouts++;
			$display("Port A read of %h got no ready within %0d cycles", addr, READY_LIMIT);
		end
		// Request stays up through the cycle after ready
		@(negedge clock);
		pa_request = 1'b0;
		@(negedge clock);
	endtask

	task automatic transfer_b(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] data);
		int start;
		int waited;
		start          = tb_cycles;
		waited         = 0;
		data           = 32'h0;
		pb_req.request = 1'b1;
		pb_req.rw      = rw;
		pb_req.address = addr;
		pb_req.wdata   = wdata;
		@(negedge clock);
		while (!pb_rsp.ready && waited < READY_LIMIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (pb_rsp.ready)
		begin
			data       = pb_rsp.rdata;
			b_ready_at = tb_cycles;
			b_latency  = tb_cycles - start;
			b_done++;
			last_b = 1'b1;
		end
		else
		begin
			timeouts++;
			$display("Port B %s of %h got no ready within %0d cycles",
				rw ? "write" : "read", addr, READY_LIMIT);
		end
		// Request stays up through the cycle after ready
		@(negedge clock);
		pb_req = '0;
		@(negedge clock);
	endtask

	task automatic read_b(input logic [31:0] addr, output logic [31:0] data);
		transfer_b(1'b0, addr, 32'h0, data);
	endtask

	task automatic write_b(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] ignored;
		transfer_b(1'b1, addr, wdata, ignored);
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic rom_reads();
		logic [31:0] data;
		int          word;
		for (int i = 0; i <= ROM_WORDS; i++)
		begin
			// Last pass goes past the end and wraps to word 5
			word = (i < ROM_WORDS) ? i : ROM_WORDS + 5;
			read_a(ROM_BASE + 32'(word * 4), data);
			compare_word(data, rom_model[word % ROM_WORDS], $sformatf("ROM word %0d", word));
			compare_word(32'(a_latency), ACCESS_CYCLES, "port A ROM read latency");
		end
	endtask

	task automatic ram_random_access();
		logic [31:0] r;
		logic [31:0] wdata;
		logic [31:0] data;
		int          idx;
		int          j;
		int          tmp;
		for (int i = 0; i < RAM_TRIES; i++)
		begin
			take_bits(10, r);
			idx = int'(r) % RAM_WORDS;
			take_bits(32, wdata);
			write_b(RAM_BASE + 32'(idx * 4), wdata);
			ram_model[idx] = wdata;
			ram_written[i] = idx;
		end
		// Index past RAM_WORDS aliases the first word written
		take_bits(32, wdata);
		write_b(RAM_BASE + 32'((RAM_WORDS + ram_written[0]) * 4), wdata);
		ram_model[ram_written[0]] = wdata;
		// Fisher-Yates shuffle of the read order
		for (int i = RAM_TRIES - 1; i > 0; i--)
		begin
			take_bits(5, r);
			j              = int'(r) % (i + 1);
			tmp            = ram_written[i];
			ram_written[i] = ram_written[j];
			ram_written[j] = tmp;
		end
		for (int i = 0; i < RAM_TRIES; i++)
		begin
			read_b(RAM_BASE + 32'(ram_written[i] * 4), data);
			compare_word(data, ram_model[ram_written[i]],
				$sformatf("RAM word %0d", ram_written[i]));
		end
		// ROM contents survive a write
		take_bits(32, wdata);
		write_b(ROM_BASE + 32'h0c, wdata);
		read_a(ROM_BASE + 32'h0c, data);
		compare_word(data, rom_model[3], "ROM word 3 after port B write");
	endtask

	task automatic led_write_read();
		logic [31:0] wdata;
		logic [31:0] data;
		for (int i = 0; i < 2; i++)
		begin
			take_bits(32, wdata);
			fork
				write_b(LED_BASE, wdata);
				begin
					// Outputs are looked at in the cycle after ready
					@(negedge clock);
					while (!pb_rsp.ready)
						@(negedge clock);
					@(negedge clock);
					compare_word(32'(leds), 32'(wdata[LED_WIDTH-1:0]),
						"LED outputs after write");
				end
			join
			read_b(LED_BASE, data);
			compare_word(data, 32'(wdata[LED_WIDTH-1:0]), "LED register read back");
		end
	endtask

	task automatic port_contention();
		logic [31:0] r;
		logic [31:0] da;
		logic [31:0] db;
		int          rom_word;
		int          ram_word;
		logic        b_first;
		for (int i = 0; i < 8; i++)
		begin
			take_bits(4, r);
			rom_word = int'(r) % ROM_WORDS;
			take_bits(5, r);
			ram_word = ram_written[int'(r) % RAM_TRIES];
			// Round robin, the port not served last goes first
			b_first = !last_b;
			fork
				read_a(ROM_BASE + 32'(rom_word * 4), da);
				read_b(RAM_BASE + 32'(ram_word * 4), db);
			join
			compare_word(da, rom_model[rom_word], "ROM word under contention");
			compare_word(db, ram_model[ram_word], "RAM word under contention");
			if (b_first)
				compare_word(32'(a_ready_at - b_ready_at), SLOT_CYCLES, "port A wait behind B");
			else
				compare_word(32'(b_ready_at - a_ready_at), SLOT_CYCLES, "port B wait behind A");
		end
	endtask

	task automatic timer_registers();
		logic [31:0] t0;
		logic [31:0] t1;
		logic [31:0] data;
		int          r0;
		int          expect_a;
		int          expect_b;
		read_b(TIMER_BASE + 32'({TMR_CYCLES, 2'b00}), t0);
		r0 = b_ready_at;
		read_b(TIMER_BASE + 32'({TMR_CYCLES, 2'b00}), t1);
		compare_word(t1 - t0, 32'(b_ready_at - r0), "timer cycle delta");
		expect_a = a_done;
		read_b(TIMER_BASE + 32'({TMR_PA_COUNT, 2'b00}), data);
		compare_word(data, 32'(expect_a), "timer port A count");
		expect_b = b_done;
		read_b(TIMER_BASE + 32'({TMR_PB_COUNT, 2'b00}), data);
		compare_word(data, 32'(expect_b), "timer port B count");
	endtask

	task automatic unmapped_read();
		logic [31:0] data;
		read_b(32'h3000_0000, data);
		compare_word(data, 32'h0, "unmapped read data");
		compare_word(32'(b_latency), ACCESS_CYCLES, "unmapped read latency");
		// Bus still alive on both ports
		read_a(ROM_BASE + 32'h1c, data);
		compare_word(data, rom_model[7], "ROM word 7 after unmapped read");
		read_b(RAM_BASE + 32'(ram_written[1] * 4), data);
		compare_word(data, ram_model[ram_written[1]], "RAM word after unmapped read");
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================

	initial
	begin
		rst_n      = 1'b0;
		pa_request = 1'b0;
		pa_address = 32'h0;
		pb_req     = '0;
		$readmemh("boot_rom.hex", rom_model);
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		compare_word(32'({pa_rsp.ready, pb_rsp.ready}), 32'h0, "ready outputs after reset");
		compare_word(32'(leds), 32'h0, "LED outputs after reset");
		rom_reads();
		ram_random_access();
		led_write_read();
		port_contention();
		timer_registers();
		unmapped_read();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		repeat (PLANNED * 12 + 200) @(posedge clock);
		$display("Watchdog ran out after %0d cycles, the tests did not finish",
			PLANNED * 12 + 200);
		$display("sim failed");
		$finish;
	end

endmodule

// File: boot_rom.hex
// Boot ROM image, one 32-bit word per line in hex, word 0 first
00000013
00100093
00200113
002081b3
40110233
0041a023
0001a283
00128293
fe029ee3
50000337
00532023
600003b7
0003a403
0000006f
deadbeef
cafef00d

// File: sources.f
rtl/soc_pkg.sv
rtl/bus_access.sv
rtl/bus_decoder.sv
rtl/block_ram.sv
rtl/boot_rom.sv
rtl/led_port.sv
rtl/cycle_timer.sv
rtl/soc_top.sv
sim/tb_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
	-f sources.f -o tb_soc_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/tb_soc_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "sim failed" "$log_file"; then
	echo "Failure reported in $log_file"
	exit 1
fi

exit 0
